//--- verilog/mcu_sram_pkg.sv
/*
 * MCU SRAM controller shared definitions
 * Sizes of the SRAM behind the fabric, the vector types that carry
 * addresses, data and check bits, and the request/response structs
 * used between the fabric, the controller stages and the SRAM macro
 */
`default_nettype none

package mcu_sram_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int SRAM_SIZE_KB      = 16;
    localparam int SRAM_DATA_W       = 32;
    // 6 Hamming bits plus overall parity
    localparam int SRAM_ECC_W        = 7;
    localparam int SRAM_DEPTH        = (SRAM_SIZE_KB * 1024) / (SRAM_DATA_W / 8);
    localparam int SRAM_ADDR_W       = $clog2(SRAM_DEPTH);
    // Byte address bits that span the whole SRAM
    localparam int CIF_ADDR_W        = SRAM_ADDR_W + $clog2(SRAM_DATA_W / 8);
    // Exec region grows in 4 KB steps
    localparam int REGION_STEP_SHIFT = 12;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [SRAM_DATA_W-1:0]     sram_data_t;
    typedef logic [SRAM_ECC_W-1:0]      sram_ecc_t;
    typedef logic [SRAM_ADDR_W-1:0]     sram_addr_t;
    typedef logic [31:0]                cif_addr_t;
    // Step count, 0 means one 4 KB step
    typedef logic [15:0]                region_size_t;
    typedef logic [SRAM_DATA_W/8-1:0]   byte_strb_t;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    // Fabric request, held stable while hold is high
    typedef struct packed {
        logic       dv;
        cif_addr_t  addr;
        logic       write;
        sram_data_t wdata;
        byte_strb_t wstrb;
    } cif_req_t;

    // Requester privilege bits
    typedef struct packed {
        logic debug;
        logic mcu_lsu;
        logic mcu_ifu;
        logic cptra;
    } req_agent_t;

    // Fabric response
    typedef struct packed {
        logic       hold;
        logic       error;
        sram_data_t rdata;
    } cif_resp_t;

    // Request to the SRAM macro
    typedef struct packed {
        logic       cs;
        logic       we;
        sram_addr_t addr;
        sram_data_t wdata;
        sram_ecc_t  ecc;
    } sram_req_t;

    // Read word from the SRAM macro, one cycle after the read
    typedef struct packed {
        sram_data_t rdata;
        sram_ecc_t  ecc;
    } sram_resp_t;

endpackage

`default_nettype wire

//--- verilog/mcu_sram_access_filter.sv
/*
 * MCU SRAM access filter
 * Splits the SRAM into the exec region (low addresses, sized in 4 KB
 * steps) and the protected region, tracks who owns the exec region
 * and grants or denies each fabric request by requester privilege
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_sram_access_filter (
    input  logic                      clk,
    input  logic                      rst_b,
    input  logic                      mcu_rst_b,
    input  logic                      fw_exec_region_lock,
    input  mcu_sram_pkg::region_size_t fw_sram_exec_region_size,
    input  mcu_sram_pkg::cif_req_t    cif_req,
    input  mcu_sram_pkg::req_agent_t  agent,
    output logic                      grant,
    output logic                      deny
);
    import mcu_sram_pkg::*;

    // Wide enough for (0xFFFF + 1) << 12
    logic [$bits(region_size_t)+REGION_STEP_SHIFT:0] exec_bytes;
    logic [$bits(region_size_t)+REGION_STEP_SHIFT:0] exec_end_calc;
    logic                                            exec_overflow;
    logic [CIF_ADDR_W-1:0]                           exec_end;
    logic                                            exec_match;
    logic                                            mcu_owned;
    logic                                            exec_ok;
    logic                                            prot_ok;
    logic                                            agent_ok;

    ////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////

    // Region size in bytes, then last byte of the exec region
    assign exec_bytes = ({{(REGION_STEP_SHIFT+1){1'b0}}, fw_sram_exec_region_size} + 1'b1)
                        << REGION_STEP_SHIFT;
    assign exec_end_calc = exec_bytes - 1'b1;

    // Any bit above the SRAM span means the setting exceeds the SRAM
    assign exec_overflow = |exec_end_calc[$bits(region_size_t)+REGION_STEP_SHIFT:CIF_ADDR_W];

    // Clamp to the last SRAM byte, whole SRAM is exec region
    assign exec_end = exec_overflow ? CIF_ADDR_W'(SRAM_SIZE_KB * 1024 - 1)
                                    : exec_end_calc[CIF_ADDR_W-1:0];

    // Only the address bits inside the SRAM span are decoded
    assign exec_match = (cif_req.addr[CIF_ADDR_W-1:0] <= exec_end);

    ////////////////////////////////////////
    // Exec region ownership
    ////////////////////////////////////////

    // MCU keeps ownership after unlock until it is held in reset,
    // it may still be fetching from the exec region
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mcu_owned <= 1'b0;
        end else if (fw_exec_region_lock) begin
            mcu_owned <= 1'b1;
        end else if (!mcu_rst_b) begin
            mcu_owned <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Privilege check
    ////////////////////////////////////////

    // Exec region agents depend on the owner
    assign exec_ok = mcu_owned ? (agent.mcu_lsu | agent.mcu_ifu | agent.debug)
                               : (agent.cptra | agent.debug);

    // Protected region is MCU data and debug only
    assign prot_ok  = agent.mcu_lsu | agent.debug;
    assign agent_ok = exec_match ? exec_ok : prot_ok;

    // Both low without a request
    assign grant = cif_req.dv & agent_ok;
    assign deny  = cif_req.dv & ~agent_ok;

    // A request is either passed on or rejected, never both
    a_grant_deny_excl: assert property (@(posedge clk) disable iff (!rst_b)
        !(grant && deny));

endmodule

`default_nettype wire

//--- verilog/mcu_sram_txn_seq.sv
/*
 * MCU SRAM transaction sequencer
 * Turns a granted fabric request into SRAM cycles. Full writes take one
 * cycle, reads and partial-strobe writes take two with hold high in the
 * first. Builds the merged read-modify-write word and the fabric response
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_sram_txn_seq (
    input  logic                     clk,
    input  logic                     rst_b,
    input  mcu_sram_pkg::cif_req_t   cif_req,
    input  logic                     grant,
    input  logic                     deny,
    input  mcu_sram_pkg::sram_data_t rd_data,
    input  logic                     double_err,
    output mcu_sram_pkg::cif_resp_t  cif_resp,
    output logic                     sram_cs,
    output logic                     sram_we,
    output mcu_sram_pkg::sram_addr_t sram_addr,
    output mcu_sram_pkg::sram_data_t wr_data,
    output logic                     rd_check
);
    import mcu_sram_pkg::*;

    logic       rd_req;
    logic       full_wr_req;
    logic       rmw_req;
    logic       rmw_wr;
    logic       second_cycle;
    sram_data_t rmw_data;

    // Request classes, only for granted requests
    assign rd_req      = grant & ~cif_req.write;
    assign full_wr_req = grant & cif_req.write & (&cif_req.wstrb);
    assign rmw_req     = grant & cif_req.write & ~(&cif_req.wstrb);

    // Set for the cycle after a read or the RMW read phase.
    // The requester is holding the same request in that cycle
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            second_cycle <= 1'b0;
        end else begin
            second_cycle <= (rd_req | rmw_req) & ~second_cycle;
        end
    end

    ////////////////////////////////////////
    // SRAM request
    ////////////////////////////////////////

    // RMW write-back only with clean or corrected read data
    assign rmw_wr = rmw_req & second_cycle & ~double_err;

    // First cycle of any granted request, plus the RMW write-back
    assign sram_cs = (grant & ~second_cycle) | rmw_wr;
    assign sram_we = (full_wr_req & ~second_cycle) | rmw_wr;

    // Word address, quiet when no access
    assign sram_addr = sram_cs ? cif_req.addr[CIF_ADDR_W-1:2] : '0;

    // New bytes where strobed, corrected old bytes elsewhere
    always_comb begin
        for (int b = 0; b < $bits(byte_strb_t); b++) begin
            rmw_data[b*8 +: 8] = cif_req.wstrb[b] ? cif_req.wdata[b*8 +: 8]
                                                  : rd_data[b*8 +: 8];
        end
    end

    assign wr_data = rmw_wr      ? rmw_data      :
                     sram_we     ? cif_req.wdata :
                     '0;

    // Read word from the SRAM is due in every second cycle
    assign rd_check = second_cycle;

    ////////////////////////////////////////
    // Fabric response
    ////////////////////////////////////////

    always_comb begin
        // Stall the requester while the SRAM read is in flight
        cif_resp.hold  = (rd_req | rmw_req) & ~second_cycle;
        // Privilege errors in the first cycle, ECC errors in the second
        cif_resp.error = deny | (second_cycle & double_err);
        // Read data only for plain reads, not the RMW read phase
        cif_resp.rdata = (second_cycle & rd_req) ? rd_data : '0;
    end

    // Write strobe only with chip select
    a_we_needs_cs: assert property (@(posedge clk) disable iff (!rst_b)
        sram_we |-> sram_cs);

    // Hold lasts exactly one cycle and is low in the data cycle
    a_hold_one_cycle: assert property (@(posedge clk) disable iff (!rst_b)
        cif_resp.hold |=> (second_cycle && !cif_resp.hold));

endmodule

`default_nettype wire

//--- verilog/mcu_sram_ecc_port.sv
/*
 * MCU SRAM ECC port
 * Hamming SECDED (39,32) on the SRAM data path. Writes get 6 Hamming
 * check bits plus an overall parity bit. Reads are decoded on demand,
 * single-bit errors are corrected and double-bit errors are flagged
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_sram_ecc_port (
    input  logic                     sram_cs,
    input  logic                     sram_we,
    input  mcu_sram_pkg::sram_addr_t sram_addr,
    input  mcu_sram_pkg::sram_data_t wr_data,
    input  logic                     rd_check,
    input  mcu_sram_pkg::sram_resp_t sram_resp,
    output mcu_sram_pkg::sram_req_t  sram_req,
    output mcu_sram_pkg::sram_data_t rd_data,
    output logic                     single_err,
    output logic                     double_err
);
    import mcu_sram_pkg::*;

    sram_ecc_t               rd_calc;
    logic [SRAM_ECC_W-2:0]   syndrome;
    logic                    parity_err;

    ////////////////////////////////////////
    // Check bit generation
    ////////////////////////////////////////

    // Data bits fill codeword positions 1..38 that are not powers of two,
    // Hamming bit k covers positions with bit k set
    function automatic sram_ecc_t ecc_encode(input sram_data_t d);
        sram_ecc_t   ecc;
        int unsigned j;
        ecc = '0;
        j   = 0;
        for (int unsigned pos = 1; pos < SRAM_DATA_W + SRAM_ECC_W; pos++) begin
            // Skip check bit positions
            if ((pos & (pos - 1)) != 0) begin
                for (int k = 0; k < SRAM_ECC_W - 1; k++) begin
                    if (pos[k]) begin
                        ecc[k] = ecc[k] ^ d[j];
                    end
                end
                j++;
            end
        end
        // Overall parity over data and Hamming bits
        ecc[SRAM_ECC_W-1] = ^d ^ (^ecc[SRAM_ECC_W-2:0]);
        return ecc;
    endfunction

    // Flip the data bit sitting at codeword position syn
    function automatic sram_data_t ecc_correct(input sram_data_t d,
                                               input logic [SRAM_ECC_W-2:0] syn);
        sram_data_t  fixed;
        int unsigned j;
        fixed = d;
        j     = 0;
        for (int unsigned pos = 1; pos < SRAM_DATA_W + SRAM_ECC_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (pos == syn) begin
                    fixed[j] = ~d[j];
                end
                j++;
            end
        end
        return fixed;
    endfunction

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    always_comb begin
        sram_req.cs    = sram_cs;
        sram_req.we    = sram_we;
        sram_req.addr  = sram_addr;
        sram_req.wdata = wr_data;
        // Data is zero when not writing, so are the check bits
        sram_req.ecc   = ecc_encode(wr_data);
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    assign rd_calc  = ecc_encode(sram_resp.rdata);
    assign syndrome = rd_calc[SRAM_ECC_W-2:0] ^ sram_resp.ecc[SRAM_ECC_W-2:0];

    // Stored codeword has even parity when clean
    assign parity_err = ^{sram_resp.rdata, sram_resp.ecc};

    // Odd parity means one flipped bit, possibly a check bit.
    // Even parity with a syndrome means two flipped bits
    assign single_err = rd_check & parity_err;
    assign double_err = rd_check & ~parity_err & (syndrome != '0);

    // Check bit or parity bit hits leave the data as read
    assign rd_data = single_err ? ecc_correct(sram_resp.rdata, syndrome)
                                : sram_resp.rdata;

    // No clock in this block, checked on settled values
    always_comb begin
        a_flags_excl: assert final (!(single_err && double_err));
    end

endmodule

`default_nettype wire

//--- verilog/mcu_sram_ctrl.sv
/*
 * MCU SRAM controller
 * Puts one single-port ECC-protected SRAM behind the internal fabric.
 * Access filter, transaction sequencer and ECC port in a chain
 */
`timescale 1ns/1ps
`default_nettype none

module mcu_sram_ctrl (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       mcu_rst_b,
    input  logic                       fw_exec_region_lock,
    input  mcu_sram_pkg::region_size_t fw_sram_exec_region_size,
    input  mcu_sram_pkg::cif_req_t     cif_req,
    input  mcu_sram_pkg::req_agent_t   agent,
    input  mcu_sram_pkg::sram_resp_t   sram_resp,
    output mcu_sram_pkg::cif_resp_t    cif_resp,
    output mcu_sram_pkg::sram_req_t    sram_req,
    output logic                       sram_single_ecc_error,
    output logic                       sram_double_ecc_error
);
    import mcu_sram_pkg::*;

    // Filter to sequencer
    logic       grant;
    logic       deny;

    // Sequencer to ECC port
    logic       sram_cs;
    logic       sram_we;
    sram_addr_t sram_addr;
    sram_data_t wr_data;
    logic       rd_check;

    // ECC port back to sequencer
    sram_data_t rd_data;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////

    // Region and privilege check
    mcu_sram_access_filter u_filter (
        .clk                      (clk),
        .rst_b                    (rst_b),
        .mcu_rst_b                (mcu_rst_b),
        .fw_exec_region_lock      (fw_exec_region_lock),
        .fw_sram_exec_region_size (fw_sram_exec_region_size),
        .cif_req                  (cif_req),
        .agent                    (agent),
        .grant                    (grant),
        .deny                     (deny)
    );

    // One or two cycle sequencing
    mcu_sram_txn_seq u_seq (
        .clk        (clk),
        .rst_b      (rst_b),
        .cif_req    (cif_req),
        .grant      (grant),
        .deny       (deny),
        .rd_data    (rd_data),
        .double_err (sram_double_ecc_error),
        .cif_resp   (cif_resp),
        .sram_cs    (sram_cs),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .wr_data    (wr_data),
        .rd_check   (rd_check)
    );

    // SECDED on the macro interface
    mcu_sram_ecc_port u_ecc (
        .sram_cs    (sram_cs),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .wr_data    (wr_data),
        .rd_check   (rd_check),
        .sram_resp  (sram_resp),
        .sram_req   (sram_req),
        .rd_data    (rd_data),
        .single_err (sram_single_ecc_error),
        .double_err (sram_double_ecc_error)
    );

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 * Free-running clock and an active-low reset held for a number of cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_b
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release on a rising edge so the first request sees a clean reset
    initial begin
        rst_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_b <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_sram_model.sv
/*
 * Behavioural single-port SRAM
 * Read word appears one cycle after the read. Data and check bits are
 * stored side by side so the testbench can flip any stored bit
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model (
    input  logic                     clk,
    input  mcu_sram_pkg::sram_req_t  sram_req,
    output mcu_sram_pkg::sram_resp_t sram_resp
);
    import mcu_sram_pkg::*;

    // Data in the upper bits, check bits below, same order as sram_resp_t
    logic [SRAM_DATA_W+SRAM_ECC_W-1:0] mem [SRAM_DEPTH];
    sram_resp_t                        rd_q;

    // Zero data with zero check bits is a clean codeword
    initial begin
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            mem[i] = '0;
        end
        rd_q = '0;
    end

    always @(posedge clk) begin
        if (sram_req.cs) begin
            if (sram_req.we) begin
                mem[sram_req.addr] <= {sram_req.wdata, sram_req.ecc};
            end else begin
                rd_q <= mem[sram_req.addr];
            end
        end
    end

    assign sram_resp = rd_q;

endmodule

`default_nettype wire

//--- bench/tb_mcu_sram_ctrl.sv
/*
 * MCU SRAM controller testbench
 * Directed tests for round trips, partial writes, region and privilege
 * rules and ECC handling, checked against a shadow copy of the SRAM
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_sram_ctrl;
    import mcu_sram_pkg::*;

    localparam int N_RT      = 16;
    localparam int N_PW      = 12;
    localparam int N_ECC     = 8;
    localparam int RESET_CYC = 5;
    // Worst case for one access including the idle cycle after it
    localparam int ACC_CYC   = 4;
    localparam int CODE_W    = SRAM_DATA_W + SRAM_ECC_W;
    localparam int T1_CYC    = 2 * N_RT * ACC_CYC;
    localparam int T2_CYC    = 3 * N_PW * ACC_CYC;
    // Seven agent sweeps of sixteen accesses, seven config changes
    localparam int T3_CYC    = 7 * 16 * ACC_CYC + 7 * 2;
    localparam int T4_CYC    = N_ECC * (3 * ACC_CYC + 1);
    localparam int T5_CYC    = N_ECC * (4 * ACC_CYC + 2);
    // Twice the summed test lengths
    localparam int TIMEOUT_CYC = 2 * (RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

    localparam req_agent_t AG_DEBUG = 4'b1000;

    typedef logic [CODE_W-1:0] codeword_t;

    logic         clk;
    logic         rst_b;
    logic         mcu_rst_b;
    logic         fw_exec_region_lock;
    region_size_t fw_sram_exec_region_size;
    cif_req_t     cif_req;
    req_agent_t   agent;
    sram_resp_t   sram_resp;
    cif_resp_t    cif_resp;
    sram_req_t    sram_req;
    logic         sram_single_ecc_error;
    logic         sram_double_ecc_error;

    // Expected SRAM contents and exec region owner
    sram_data_t   shadow [SRAM_DEPTH];
    logic         owner_mcu;
    integer       seed;
    int           err_cnt;
    int           n_checks;
    int           n_tests;
    int           n_passed;
    int           cycle_cnt;
    string        cur_test;

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYC)) u_clk (
        .clk   (clk),
        .rst_b (rst_b)
    );

    mcu_sram_ctrl dut (
        .clk                      (clk),
        .rst_b                    (rst_b),
        .mcu_rst_b                (mcu_rst_b),
        .fw_exec_region_lock      (fw_exec_region_lock),
        .fw_sram_exec_region_size (fw_sram_exec_region_size),
        .cif_req                  (cif_req),
        .agent                    (agent),
        .sram_resp                (sram_resp),
        .cif_resp                 (cif_resp),
        .sram_req                 (sram_req),
        .sram_single_ecc_error    (sram_single_ecc_error),
        .sram_double_ecc_error    (sram_double_ecc_error)
    );

    tb_sram_model u_sram (
        .clk       (clk),
        .sram_req  (sram_req),
        .sram_resp (sram_resp)
    );

    ////////////////////////////////////////
    // Reference helpers
    ////////////////////////////////////////

    function automatic sram_addr_t word_of(input cif_addr_t a);
        return a[CIF_ADDR_W-1:2];
    endfunction

    // Word aligned, anywhere in the SRAM
    function automatic cif_addr_t rand_addr();
        cif_addr_t a;
        a = $random(seed);
        a[31:CIF_ADDR_W] = '0;
        a[1:0] = 2'b00;
        return a;
    endfunction

    // Index 0 debug, 1 MCU load/store, 2 MCU fetch, 3 Caliptra
    function automatic req_agent_t agent_by_index(input int i);
        return req_agent_t'(4'b1000 >> i);
    endfunction

    function automatic sram_data_t merge_bytes(input sram_data_t old, input sram_data_t new_data,
                                               input byte_strb_t strb);
        sram_data_t m;
        m = old;
        for (int b = 0; b < $bits(byte_strb_t); b++) begin
            if (strb[b]) begin
                m[8*b +: 8] = new_data[8*b +: 8];
            end
        end
        return m;
    endfunction

    function automatic logic allowed_for(input cif_addr_t addr, input req_agent_t who);
        logic in_exec;
        // Exec region is size + 1 steps of 4 KB from address 0
        in_exec = (int'(addr[CIF_ADDR_W-1:0]) >> REGION_STEP_SHIFT)
                  <= int'(fw_sram_exec_region_size);
        if (!in_exec) begin
            return who.mcu_lsu | who.debug;
        end else if (owner_mcu) begin
            return who.mcu_lsu | who.mcu_ifu | who.debug;
        end else begin
            return who.cptra | who.debug;
        end
    endfunction

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        value_ok: assert (act === exp) else begin
            $display("Error in %s, %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // Fabric access
    ////////////////////////////////////////

    task automatic access(input cif_addr_t addr, input logic write, input sram_data_t wdata,
                          input byte_strb_t strb, input req_agent_t who,
                          output cif_resp_t resp, output int holds, output logic first_cs,
                          output logic single, output logic dbl);
        cif_req_t r;
        r.dv    = 1'b1;
        r.addr  = addr;
        r.write = write;
        r.wdata = wdata;
        r.wstrb = strb;
        @(posedge clk);
        cif_req <= r;
        agent   <= who;
        @(negedge clk);
        first_cs = sram_req.cs;
        holds    = 0;
        // Request stays stable while held
        while (cif_resp.hold) begin
            holds++;
            @(negedge clk);
        end
        resp   = cif_resp;
        single = sram_single_ecc_error;
        dbl    = sram_double_ecc_error;
        @(posedge clk);
        cif_req <= '0;
        agent   <= '0;
    endtask

    task automatic write_word(input cif_addr_t addr, input sram_data_t data, input byte_strb_t strb,
                              input req_agent_t who, input logic allowed, input logic exp_dbl);
        cif_resp_t  resp;
        int         holds;
        logic       first_cs;
        logic       single;
        logic       dbl;
        sram_addr_t w;
        w = word_of(addr);
        access(addr, 1'b1, data, strb, who, resp, holds, first_cs, single, dbl);
        compare("write error", !allowed | exp_dbl, resp.error);
        // Partial strobes read first
        compare("write hold cycles", (allowed && !(&strb)) ? 1 : 0, holds);
        compare("SRAM select in first cycle", allowed, first_cs);
        compare("write double flag", exp_dbl, dbl);
        if (allowed && !exp_dbl) begin
            shadow[w] = merge_bytes(shadow[w], data, strb);
        end
    endtask

    task automatic read_word(input cif_addr_t addr, input req_agent_t who, input logic allowed,
                             input logic exp_single, input logic exp_dbl);
        cif_resp_t resp;
        int        holds;
        logic      first_cs;
        logic      single;
        logic      dbl;
        access(addr, 1'b0, '0, '0, who, resp, holds, first_cs, single, dbl);
        compare("read error", !allowed | exp_dbl, resp.error);
        compare("read hold cycles", allowed ? 1 : 0, holds);
        compare("SRAM select in first cycle", allowed, first_cs);
        compare("single flag", exp_single, single);
        compare("double flag", exp_dbl, dbl);
        if (allowed && !exp_dbl) begin
            compare($sformatf("read data at 0x%0h", addr), shadow[word_of(addr)], resp.rdata);
        end
    endtask

    // Negedge keeps clear of the model's write at the clock edge
    task automatic flip_bits(input cif_addr_t addr, input codeword_t mask);
        @(negedge clk);
        u_sram.mem[word_of(addr)] = u_sram.mem[word_of(addr)] ^ mask;
    endtask

    task automatic set_config(input logic lock, input logic mrst, input region_size_t size);
        @(posedge clk);
        fw_exec_region_lock      <= lock;
        mcu_rst_b                <= mrst;
        fw_sram_exec_region_size <= size;
        if (lock) begin
            owner_mcu = 1'b1;
        end else if (!mrst) begin
            owner_mcu = 1'b0;
        end
        // Ownership flag picks up the new inputs here
        @(posedge clk);
    endtask

    // Each agent writes and reads, debug sets and checks the word
    task automatic sweep_agents(input cif_addr_t addr);
        req_agent_t who;
        for (int i = 0; i < 4; i++) begin
            who = agent_by_index(i);
            write_word(addr, $random(seed), '1, AG_DEBUG, 1'b1, 1'b0);
            write_word(addr, $random(seed), '1, who, allowed_for(addr, who), 1'b0);
            read_word(addr, who, allowed_for(addr, who), 1'b0, 1'b0);
            read_word(addr, AG_DEBUG, 1'b1, 1'b0, 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic round_trip();
        cif_addr_t addrs [N_RT];
        for (int i = 0; i < N_RT; i++) begin
            addrs[i] = rand_addr();
            write_word(addrs[i], $random(seed), '1, AG_DEBUG, 1'b1, 1'b0);
        end
        for (int i = 0; i < N_RT; i++) begin
            read_word(addrs[i], AG_DEBUG, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic partial_writes();
        cif_addr_t  a;
        byte_strb_t strb;
        for (int i = 0; i < N_PW; i++) begin
            a    = rand_addr();
            // Never all four bytes
            strb = byte_strb_t'($unsigned($random(seed)) % 15);
            write_word(a, $random(seed), '1, AG_DEBUG, 1'b1, 1'b0);
            write_word(a, $random(seed), strb, AG_DEBUG, 1'b1, 1'b0);
            read_word(a, AG_DEBUG, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic region_rules();
        cif_addr_t exec_a;
        cif_addr_t prot_a;
        exec_a = cif_addr_t'($unsigned($random(seed)) % 1024) << 2;
        prot_a = 32'h1000 + (cif_addr_t'($unsigned($random(seed)) % 3072) << 2);
        // 4 KB exec region, unlocked, MCU in reset
        set_config(1'b0, 1'b0, 16'h0000);
        sweep_agents(exec_a);
        sweep_agents(prot_a);
        // Lock hands the exec region to the MCU
        set_config(1'b1, 1'b1, 16'h0000);
        sweep_agents(exec_a);
        // Unlock with the MCU running, MCU keeps it
        set_config(1'b0, 1'b1, 16'h0000);
        sweep_agents(exec_a);
        set_config(1'b0, 1'b0, 16'h0000);
        sweep_agents(exec_a);
        // Sizes past 16 KB clamp to the whole SRAM
        set_config(1'b0, 1'b0, 16'h0004);
        sweep_agents(prot_a);
        set_config(1'b0, 1'b0, 16'hFFFF);
        sweep_agents(32'h0000_3FFC);
        set_config(1'b0, 1'b0, 16'h0000);
    endtask

    task automatic single_bit_fix();
        cif_addr_t a;
        int        b;
        for (int i = 0; i < N_ECC; i++) begin
            a = rand_addr();
            b = $unsigned($random(seed)) % CODE_W;
            write_word(a, $random(seed), '1, AG_DEBUG, 1'b1, 1'b0);
            flip_bits(a, codeword_t'(1) << b);
            read_word(a, AG_DEBUG, 1'b1, 1'b1, 1'b0);
            // Scrub
            write_word(a, shadow[word_of(a)], '1, AG_DEBUG, 1'b1, 1'b0);
        end
    endtask

    task automatic double_bit_detect();
        cif_addr_t  a;
        int         b1;
        int         b2;
        byte_strb_t strb;
        codeword_t  stored;
        for (int i = 0; i < N_ECC; i++) begin
            a    = rand_addr();
            b1   = $unsigned($random(seed)) % CODE_W;
            // Second bit always differs from the first
            b2   = (b1 + 1 + $unsigned($random(seed)) % (CODE_W - 1)) % CODE_W;
            strb = byte_strb_t'($unsigned($random(seed)) % 15);
            write_word(a, $random(seed), '1, AG_DEBUG, 1'b1, 1'b0);
            flip_bits(a, (codeword_t'(1) << b1) | (codeword_t'(1) << b2));
            read_word(a, AG_DEBUG, 1'b1, 1'b0, 1'b1);
            stored = u_sram.mem[word_of(a)];
            write_word(a, $random(seed), strb, AG_DEBUG, 1'b1, 1'b1);
            @(negedge clk);
            compare("stored word after suppressed RMW", stored, u_sram.mem[word_of(a)]);
            write_word(a, shadow[word_of(a)], '1, AG_DEBUG, 1'b1, 1'b0);
        end
    endtask

    task automatic report_test(input int errs_at_start);
        n_tests++;
        if (err_cnt == errs_at_start) begin
            n_passed++;
            $display("Test %s: ok", cur_test);
        end else begin
            $display("Test %s: %0d errors", cur_test, err_cnt - errs_at_start);
        end
    endtask

    ////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////

    initial begin
        int errs_at_start;
        seed                     = 79030;
        cif_req                  = '0;
        agent                    = '0;
        mcu_rst_b                = 1'b0;
        fw_exec_region_lock      = 1'b0;
        fw_sram_exec_region_size = '0;
        owner_mcu                = 1'b0;
        err_cnt                  = 0;
        n_checks                 = 0;
        n_tests                  = 0;
        n_passed                 = 0;
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            shadow[i] = '0;
        end
        wait (rst_b === 1'b1);

        errs_at_start = err_cnt;
        cur_test = "write/read round trip";
        round_trip();
        report_test(errs_at_start);

        errs_at_start = err_cnt;
        cur_test = "partial-strobe writes";
        partial_writes();
        report_test(errs_at_start);

        errs_at_start = err_cnt;
        cur_test = "region and privilege rules";
        region_rules();
        report_test(errs_at_start);

        errs_at_start = err_cnt;
        cur_test = "single-bit correction";
        single_bit_fix();
        report_test(errs_at_start);

        errs_at_start = err_cnt;
        cur_test = "double-bit detection";
        double_bit_detect();
        report_test(errs_at_start);

        $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_passed, n_tests - n_passed, n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/mcu_sram_pkg.sv
verilog/mcu_sram_access_filter.sv
verilog/mcu_sram_txn_seq.sv
verilog/mcu_sram_ecc_port.sv
verilog/mcu_sram_ctrl.sv
bench/tb_clk_gen.sv
bench/tb_sram_model.sv
bench/tb_mcu_sram_ctrl.sv
